//--- hdl/router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// input ports Local North East West South on the channel.
`define NUM_PORTS 5

// flit word width.
`define FLIT_WIDTH 32

// length field in the low bits of a header word.
`define LEN_WIDTH 12

// entries per input queue (2, 8 and 16 also work).
`define QUEUE_DEPTH 4

`endif

//--- hdl/routerPkg.sv
`include "router_defs.svh"

package routerPkg;

  // flit kind where only a header carries a length.
  typedef enum logic [2:0] {
    flitHeader = 3'b001,
    flitBody   = 3'b010,
    flitTail   = 3'b100
  } flitIdT;

  // source port number from Local 0 through South 4.
  typedef logic [2:0] portIdxT;

  // one-hot arbiter state with idle in bit 0 and the ports in bits 1..5.
  typedef logic [`NUM_PORTS:0] arbStateT;

  localparam arbStateT stateIdle = arbStateT'(1);

  // one flit word that reads as a header or as raw payload.
  typedef union packed {
    struct packed {
      logic [`FLIT_WIDTH-`LEN_WIDTH-5:0] rsvd; // unused.
      logic [3:0]                        dest; // destination node.
      logic [`LEN_WIDTH-1:0]             len;  // flits granted per slice.
    } hdr;
    logic [`FLIT_WIDTH-1:0] raw;
  } flitWordT;

endpackage

//--- hdl/flitQueue.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module flitQueue
  import routerPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     wr,
  input  flitIdT   wrFlitId,
  input  flitWordT wrWord,
  input  logic     pop,
  output logic     full,
  output logic     req,
  output flitIdT   headFlitId,
  output flitWordT headWord
);

  localparam int ptrWidth = $clog2(`QUEUE_DEPTH);

  flitIdT   idMem   [`QUEUE_DEPTH];
  flitWordT wordMem [`QUEUE_DEPTH];

  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0]   count;
  logic                doWr;
  logic                doPop;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(`QUEUE_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign doWr  = wr && !full;  // write into a full queue is lost.
  assign doPop = pop && req;

  always_ff @(posedge clk)
  begin
    if (doWr)
    begin
      idMem[wrPtr]   <= wrFlitId;
      wordMem[wrPtr] <= wrWord;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWr)
        wrPtr <= nextPtr(wrPtr);
      if (doPop)
        rdPtr <= nextPtr(rdPtr);
      if (doWr && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doWr)
        count <= count - 1'b1;
    end
  end

  assign full       = (count == (ptrWidth + 1)'(`QUEUE_DEPTH));
  assign req        = (count != '0);
  assign headFlitId = idMem[rdPtr];   // head seen before the pop.
  assign headWord   = wordMem[rdPtr];

endmodule

//--- hdl/holdTimer.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module holdTimer
  import routerPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  flitIdT   headFlitId,
  input  flitWordT headWord,
  input  logic     run,
  output logic     timesUp
);

  logic [`LEN_WIDTH-1:0] budget;
  logic [`LEN_WIDTH-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      if (headFlitId == flitHeader)
        budget <= headWord.hdr.len; // header at the head sets the slice.
      if (run)
        count <= count + 1'b1;      // one pop per running cycle.
      else
        count <= '0;
    end
  end

  // slice is spent once count reaches the budget.
  assign timesUp = (count == budget);

endmodule

//--- hdl/channelArbiter.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module channelArbiter
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  logic [`NUM_PORTS-1:0] timesUp,
  output arbStateT              state,
  output logic [`NUM_PORTS-1:0] run
);

  arbStateT nextState;
  portIdxT  curPort;

  function automatic arbStateT portState(input int idx);
    arbStateT s;
    s = '0;
    s[idx + 1] = 1'b1;
    return s;
  endfunction

  // first requester at or after start in cyclic order L N E W S, or idle if none.
  function automatic arbStateT pickNext(input logic [`NUM_PORTS-1:0] reqs, input int start);
    arbStateT pick;
    int       cand;
    pick = stateIdle;
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      cand = (start + k) % `NUM_PORTS;
      if (reqs[cand])
        pick = portState(cand); // lowest k wins.
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stateIdle;
    else
      state <= nextState;
  end

  // port that owns the current state.
  always_comb
  begin
    curPort = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (state[i + 1])
        curPort = portIdxT'(i);
    end
  end

  always_comb
  begin
    nextState = stateIdle;
    run       = '0;
    if (state == stateIdle)
    begin
      nextState = pickNext(req, 0);
    end
    else if ($onehot(state))
    begin
      if (req[curPort] && !timesUp[curPort])
      begin
        run[curPort] = 1'b1; // pop and count.
        nextState    = state;
      end
      else
      begin
        // search starts after the owner and reaches the owner itself last.
        nextState = pickNext(req, int'(curPort) + 1);
      end
    end
  end

endmodule

//--- hdl/outputStage.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module outputStage
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] run,
  input  flitIdT                headFlitId [`NUM_PORTS],
  input  flitWordT              headWord [`NUM_PORTS],
  output logic                  outValid,
  output flitIdT                outFlitId,
  output flitWordT              outData,
  output portIdxT               outPort
);

  portIdxT selPort;
  logic    anyRun;

  // at most one strobe is high.
  always_comb
  begin
    selPort = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (run[i])
        selPort = portIdxT'(i);
    end
  end

  assign anyRun = |run;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= anyRun; // one pulse per pop.
  end

  always_ff @(posedge clk)
  begin
    if (anyRun)
    begin
      outPort   <= selPort;
      outFlitId <= headFlitId[selPort];
      outData   <= headWord[selPort];
    end
  end

endmodule

//--- hdl/routerChannel.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module routerChannel
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] inWr,
  input  flitIdT                inFlitId [`NUM_PORTS],
  input  flitWordT              inWord [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] inFull,
  output logic                  outValid,
  output flitIdT                outFlitId,
  output flitWordT              outData,
  output portIdxT               outPort
);

  logic [`NUM_PORTS-1:0] req;
  logic [`NUM_PORTS-1:0] timesUp;
  logic [`NUM_PORTS-1:0] run;     // pop and timer run at once.
  flitIdT                headFlitId [`NUM_PORTS];
  flitWordT              headWord [`NUM_PORTS];

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gPort
    flitQueue uQueue (
      .clk        (clk),
      .rst        (rst),
      .wr         (inWr[p]),
      .wrFlitId   (inFlitId[p]),
      .wrWord     (inWord[p]),
      .pop        (run[p]),
      .full       (inFull[p]),
      .req        (req[p]),
      .headFlitId (headFlitId[p]),
      .headWord   (headWord[p])
    );

    holdTimer uTimer (
      .clk        (clk),
      .rst        (rst),
      .headFlitId (headFlitId[p]),
      .headWord   (headWord[p]),
      .run        (run[p]),
      .timesUp    (timesUp[p])
    );
  end

  channelArbiter uArb (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .timesUp (timesUp),
    .state   (),
    .run     (run)
  );

  outputStage uOut (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .headFlitId (headFlitId),
    .headWord   (headWord),
    .outValid   (outValid),
    .outFlitId  (outFlitId),
    .outData    (outData),
    .outPort    (outPort)
  );

endmodule

//--- test/routerChannelTb.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module routerChannelTb
  import routerPkg::*;
();

  // one golden line with the fields that its kind uses.
  typedef struct packed {
    int          test;
    int          cyc;
    int          port;
    int          id;
    logic [31:0] val;
  } lineT;

  logic                  clk;
  logic                  rst;
  logic [`NUM_PORTS-1:0] inWr;
  flitIdT                inFlitId [`NUM_PORTS];
  flitWordT              inWord [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] inFull;
  logic                  outValid;
  flitIdT                outFlitId;
  flitWordT              outData;
  portIdxT               outPort;

  lineT    wrLines[$];
  lineT    flitLines[$];
  lineT    grantLines[$];
  lineT    fullLines[$];
  lineT    expFlit [`NUM_PORTS][$];
  lineT    expGrant[$];
  int      lineCount = 0;
  int      testCount = 0;
  logic    inBurst;
  portIdxT burstPort;
  int      burstLen;

  routerChannel dut (
    .clk       (clk),
    .rst       (rst),
    .inWr      (inWr),
    .inFlitId  (inFlitId),
    .inWord    (inWord),
    .inFull    (inFull),
    .outValid  (outValid),
    .outFlitId (outFlitId),
    .outData   (outData),
    .outPort   (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compareBit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abortRun($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  task automatic compareFlitId(input string name, input flitIdT exp, input flitIdT act);
    if (act !== exp)
      abortRun($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  task automatic compareWord(input string name, input flitWordT exp, input flitWordT act);
    if (act !== exp)
      abortRun($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp.raw, act.raw));
  endtask

  task automatic comparePort(input string name, input portIdxT exp, input portIdxT act);
    if (act !== exp)
      abortRun($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp, act));
  endtask

  task automatic compareCount(input string name, input int exp, input int act);
    if (act != exp)
      abortRun($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp, act));
  endtask

  task automatic loadGolden();
    int          fd;
    int          n;
    int          want;
    int          a;
    int          b;
    int          c;
    int          d;
    logic [31:0] v;
    byte         kind;
    string       text;
    string       rest;
    fd = $fopen("test/routerChannel_golden.txt", "r");
    if (fd == 0)
      abortRun("cannot open test/routerChannel_golden.txt");
    while (!$feof(fd))
    begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() < 2)
        continue;
      kind = text.getc(0);
      rest = text.substr(1, text.len() - 1);
      n    = 0;
      want = 0;
      a    = 0;
      b    = 0;
      c    = 0;
      d    = 0;
      v    = '0;
      case (kind)
        "W":
        begin
          n    = $sscanf(rest, "%d %d %d %h %h", a, b, c, d, v);
          want = 5;
          wrLines.push_back('{a, b, c, d, v});
        end
        "E":
        begin
          n    = $sscanf(rest, "%d %d %h %h", a, c, d, v);
          want = 4;
          flitLines.push_back('{a, b, c, d, v});
        end
        "G":
        begin
          n    = $sscanf(rest, "%d %d %d", a, c, v);
          want = 3;
          grantLines.push_back('{a, b, c, d, v});
        end
        "F":
        begin
          n    = $sscanf(rest, "%d %d %d %d", a, b, c, v);
          want = 4;
          fullLines.push_back('{a, b, c, d, v});
        end
        default: ; // comment line.
      endcase
      if (n != want)
        abortRun($sformatf("golden line is malformed: %s", text));
      if (want != 0)
        lineCount++;
      if (a > testCount)
        testCount = a;
    end
    $fclose(fd);
    if (lineCount == 0)
      abortRun("the golden file holds no data lines");
  endtask

  function automatic int pendingCount();
    int total;
    total = expGrant.size();
    for (int p = 0; p < `NUM_PORTS; p++)
      total += expFlit[p].size();
    return total;
  endfunction

  task automatic driveWrite(input lineT w);
    inWr[w.port]     = 1'b1;
    inFlitId[w.port] = flitIdT'(w.id[2:0]);
    inWord[w.port]   = w.val;
  endtask

  task automatic checkIdleOutputs();
    compareBit("outValid", 1'b0, outValid);
    for (int p = 0; p < `NUM_PORTS; p++)
      compareBit($sformatf("inFull[%0d]", p), 1'b0, inFull[p]);
  endtask

  // one test loads its expectations, plays its cycles and waits for the drain.
  task automatic runTest(input int t);
    int lastCyc;
    int gap;
    lastCyc = -1;
    foreach (flitLines[i])
      if (flitLines[i].test == t)
        expFlit[flitLines[i].port].push_back(flitLines[i]);
    foreach (grantLines[i])
      if (grantLines[i].test == t)
        expGrant.push_back(grantLines[i]);
    foreach (wrLines[i])
      if (wrLines[i].test == t && wrLines[i].cyc > lastCyc)
        lastCyc = wrLines[i].cyc;
    foreach (fullLines[i])
      if (fullLines[i].test == t && fullLines[i].cyc > lastCyc)
        lastCyc = fullLines[i].cyc;
    for (int cyc = 0; cyc <= lastCyc; cyc++)
    begin
      @(negedge clk);
      inWr = '0;
      foreach (fullLines[i])
        if (fullLines[i].test == t && fullLines[i].cyc == cyc)
          compareBit($sformatf("inFull[%0d]", fullLines[i].port), fullLines[i].val[0],
                     inFull[fullLines[i].port]);
      foreach (wrLines[i])
        if (wrLines[i].test == t && wrLines[i].cyc == cyc)
          driveWrite(wrLines[i]);
    end
    @(negedge clk);
    inWr = '0;
    while (pendingCount() != 0 || inBurst)
      @(negedge clk);
    gap = $urandom_range(9, 2); // idle gap before the next test.
    repeat (gap) @(negedge clk);
  endtask

  // a burst of back-to-back valid cycles is one grant.
  task automatic checkOutput();
    lineT e;
    if (outValid)
    begin
      if (int'(outPort) >= `NUM_PORTS)
        abortRun($sformatf("output names port %0d, which does not exist", outPort));
      if (inBurst && outPort != burstPort)
        abortRun($sformatf("port %0d took the channel from port %0d with no idle cycle",
                           outPort, burstPort));
      if (!inBurst)
      begin
        inBurst   = 1'b1;
        burstPort = outPort;
        burstLen  = 0;
      end
      burstLen++;
      if (expFlit[outPort].size() == 0)
        abortRun($sformatf("port %0d sent a flit that was not expected", outPort));
      e = expFlit[outPort].pop_front();
      compareFlitId("outFlitId", flitIdT'(e.id[2:0]), outFlitId);
      compareWord("outData", e.val, outData);
    end
    else if (inBurst)
    begin
      inBurst = 1'b0;
      if (expGrant.size() == 0)
        abortRun("a grant ended that the golden file does not list");
      e = expGrant.pop_front();
      comparePort("grant port", portIdxT'(e.port), burstPort);
      compareCount("grant length", int'(e.val), burstLen);
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst)
      checkOutput();
  end

  initial
  begin
    void'($urandom(32'h72a8_2ab5));
    rst       = 1'b1;
    inWr      = '0;
    inBurst   = 1'b0;
    burstPort = '0;
    burstLen  = 0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inFlitId[p] = flitHeader;
      inWord[p]   = '0;
    end
    loadGolden();
    repeat (8)
    begin
      @(negedge clk);
      checkIdleOutputs();
    end
    rst = 1'b0;
    @(negedge clk);
    checkIdleOutputs(); // first cycle out of reset.
    for (int t = 1; t <= testCount; t++)
      runTest(t);
    repeat (10) @(negedge clk);
    $display("STATUS: PASS");
    $finish;
  end

  // 40 cycles per golden line.
  initial
  begin
    wait (lineCount > 0);
    repeat (lineCount * 40) @(posedge clk);
    $display("timeout: the channel did not deliver the expected flits in time");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- list.f
+incdir+hdl
hdl/routerPkg.sv
hdl/flitQueue.sv
hdl/holdTimer.sv
hdl/channelArbiter.sv
hdl/outputStage.sv
hdl/routerChannel.sv
test/routerChannelTb.sv

//--- Makefile
# Verilator build and run for the router output channel.

VERILATOR ?= verilator
TOP       ?= routerChannelTb
LINT_TOP  ?= routerChannel
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the run passes only if the testbench printed the pass line.
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- test/routerChannel_golden.txt
# W test cycle port id word | E test port id word | ports 0..4 are L N E W S, id and word in hex
# G test port flits (one line per grant, in grant order) | F test cycle port inFull
W 1 0 2 1 00005003
W 1 1 2 2 a1b2c3d4
W 1 2 2 4 0badf00d
E 1 2 1 00005003
E 1 2 2 a1b2c3d4
E 1 2 4 0badf00d
G 1 2 3
W 2 0 1 1 00003002
W 2 0 3 1 00001001
W 2 1 1 2 11112222
W 2 2 1 2 33334444
W 2 3 1 4 5555aaaa
E 2 1 1 00003002
E 2 1 2 11112222
E 2 1 2 33334444
E 2 1 4 5555aaaa
E 2 3 1 00001001
G 2 1 2
G 2 3 1
G 2 1 2
W 3 0 0 1 10a00001
W 3 0 1 1 21b10001
W 3 0 2 1 32c20001
W 3 0 3 1 43d30001
W 3 0 4 1 54e40001
W 3 1 0 1 65f50001
W 3 1 1 1 76060001
E 3 0 1 10a00001
E 3 0 1 65f50001
E 3 1 1 21b10001
E 3 1 1 76060001
E 3 2 1 32c20001
E 3 3 1 43d30001
E 3 4 1 54e40001
G 3 0 1
G 3 1 1
G 3 2 1
G 3 3 1
G 3 4 1
G 3 0 1
G 3 1 1
W 4 0 0 1 0000a004
W 4 0 4 1 0000b004
W 4 1 0 2 4c0ffee0
W 4 1 4 2 0f1e2d3c
W 4 2 0 2 12345678
W 4 2 4 2 4b5a6978
W 4 3 0 4 9abcdef0
W 4 3 4 4 8796a5b4
E 4 0 1 0000a004
E 4 0 2 4c0ffee0
E 4 0 2 12345678
E 4 0 4 9abcdef0
E 4 4 1 0000b004
E 4 4 2 0f1e2d3c
E 4 4 2 4b5a6978
E 4 4 4 8796a5b4
G 4 0 4
G 4 4 4
F 4 3 4 0
F 4 4 4 1
F 4 4 0 0
F 4 7 4 1
F 4 8 4 0
